// ==== source/localBusPkg.sv ====
`default_nettype none

package localBusPkg;

  localparam int addrWidth = 32; // byte address
  localparam int dataWidth = 32;

  // request opcodes
  typedef enum logic [1:0]
  {
    opRead     = 2'd0,
    opWrite    = 2'd1,
    opReadLine = 2'd2
  } lbusOp_e;

  // master states, one-hot
  typedef enum logic [4:0]
  {
    stIdle = 5'b00001,
    stAddr = 5'b00010,
    stData = 5'b00100,
    stLast = 5'b01000,
    stTurn = 5'b10000 // one dead cycle before next request
  } lbusState_e;

endpackage

`default_nettype wire

// ==== source/lbusReqIf.sv ====
`timescale 1ns/1ns
`default_nettype none

interface lbusReqIf
  import localBusPkg::*;
();
  logic                 reqValid;
  logic                 reqReady;
  lbusOp_e              reqOp;
  logic [addrWidth-1:0] reqAddr;
  logic [dataWidth-1:0] reqWdata;
  logic                 rspValid;
  logic                 rspReady;
  logic [dataWidth-1:0] rspData;
  logic                 done; // last bus beat of the transaction

  modport requester
  (
    output reqValid, reqOp, reqAddr, reqWdata, rspReady,
    input  reqReady, rspValid, rspData, done
  );

  modport controller
  (
    input  reqValid, reqOp, reqAddr, reqWdata, rspReady,
    output reqReady, rspValid, rspData, done
  );

endinterface

`default_nettype wire

// ==== source/readDataFifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module readDataFifo
  import localBusPkg::*;
#(
  parameter int fifoDepth = 4
)
(
  input  logic                 BUSCLK,
  input  logic                 reset,
  input  logic                 push,
  input  logic [dataWidth-1:0] pushData,
  output logic                 popValid,
  input  logic                 popReady,
  output logic [dataWidth-1:0] popData,
  output logic                 full
);
  localparam int ptrW = $clog2(fifoDepth);

  logic [dataWidth-1:0] mem [fifoDepth];
  logic [ptrW-1:0]      wrPtr;
  logic [ptrW-1:0]      rdPtr;
  logic [ptrW:0]        count;
  logic                 pop;

  assign pop      = popValid && popReady;
  assign popValid = count != '0;
  assign popData  = mem[rdPtr]; // fall-through head word
  assign full     = count == fifoDepth[ptrW:0];

  always_ff @(posedge BUSCLK)
  begin
    if (push)
      mem[wrPtr] <= pushData;
  end

  always_ff @(posedge BUSCLK)
  begin
    if (reset)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= wrPtr + 1'b1; // wraps, depth is a power of two
      if (pop)
        rdPtr <= rdPtr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // master holds IRDY low while full
  assert property (@(posedge BUSCLK) disable iff (reset) full |-> !push);

endmodule

`default_nettype wire

// ==== source/lbusReqArbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module lbusReqArbiter
  import localBusPkg::*;
#(
  parameter int lineWords = 4
)
(
  input  logic         BUSCLK,
  input  logic         reset,
  lbusReqIf.controller port0,
  lbusReqIf.controller port1,
  lbusReqIf.requester  toMaster
);
  localparam int owedW = $clog2(lineWords + 1);

  logic             rrPtr; // port holding priority
  logic             locked;
  logic             owner;
  logic             doneSeen;
  logic [owedW-1:0] owed;   // response words not yet handed over
  logic [owedW-1:0] owedNext;
  logic             pick;
  logic             sel;
  logic             accept;
  logic             rspXfer;
  logic             unlock;

  always_comb
  begin
    if (rrPtr)
      pick = port1.reqValid || !port0.reqValid;
    else
      pick = !port0.reqValid && port1.reqValid;
  end

  assign sel = locked ? owner : pick;

  // request path
  assign toMaster.reqValid = !locked && (port0.reqValid || port1.reqValid);
  assign toMaster.reqOp    = sel ? port1.reqOp : port0.reqOp;
  assign toMaster.reqAddr  = sel ? port1.reqAddr : port0.reqAddr;
  assign toMaster.reqWdata = sel ? port1.reqWdata : port0.reqWdata;
  assign port0.reqReady    = !locked && !pick && toMaster.reqReady;
  assign port1.reqReady    = !locked && pick && toMaster.reqReady;

  // response path back to owner only
  assign toMaster.rspReady = locked && (owner ? port1.rspReady : port0.rspReady);
  assign port0.rspValid    = locked && !owner && toMaster.rspValid;
  assign port1.rspValid    = locked && owner && toMaster.rspValid;
  assign port0.rspData     = toMaster.rspData;
  assign port1.rspData     = toMaster.rspData;
  assign port0.done        = locked && !owner && toMaster.done;
  assign port1.done        = locked && owner && toMaster.done;

  assign accept   = toMaster.reqValid && toMaster.reqReady;
  assign rspXfer  = toMaster.rspValid && toMaster.rspReady;
  assign owedNext = owed - owedW'(rspXfer);
  assign unlock   = locked && (doneSeen || toMaster.done) && owedNext == '0;

  always_ff @(posedge BUSCLK)
  begin
    if (reset)
    begin
      rrPtr    <= 1'b0;
      locked   <= 1'b0;
      owner    <= 1'b0;
      doneSeen <= 1'b0;
      owed     <= '0;
    end
    else if (accept)
    begin
      locked   <= 1'b1;
      owner    <= pick;
      doneSeen <= 1'b0;
      case (toMaster.reqOp)
        opReadLine: owed <= owedW'(lineWords);
        opRead:     owed <= owedW'(1);
        default:    owed <= '0; // writes return nothing
      endcase
    end
    else if (locked)
    begin
      owed <= owedNext;
      if (toMaster.done)
        doneSeen <= 1'b1;
      if (unlock)
      begin
        locked <= 1'b0;
        rrPtr  <= !owner; // skip the port just served
      end
    end
  end

  // owner never gets a word it did not ask for
  assert property (@(posedge BUSCLK) disable iff (reset)
    locked && rspXfer |-> owed != '0);

endmodule

`default_nettype wire

// ==== source/lbusMaster.sv ====
`timescale 1ns/1ns
`default_nettype none

module lbusMaster
  import localBusPkg::*;
#(
  parameter int lineWords = 4,
  parameter int fifoDepth = 4
)
(
  input  logic                 BUSCLK,
  input  logic                 reset,
  lbusReqIf.controller         ctl,
  input  logic                 busGnt,
  input  logic                 busTrdy,
  input  logic [dataWidth-1:0] busRdata,
  output logic                 busReq,
  output logic                 busFrame,
  output logic                 busIrdy,
  output logic                 busDrive,
  output logic                 busWrite,
  output logic [addrWidth-1:0] busAddr,
  output logic [dataWidth-1:0] busWdata
);
  localparam int cntW = $clog2(lineWords);
  localparam logic [addrWidth-1:0] lineMask = addrWidth'(lineWords * 4 - 1);

  lbusState_e           state;
  lbusState_e           stateNext;
  lbusOp_e              opReg;
  logic [addrWidth-1:0] addrReg;  // current beat address
  logic [dataWidth-1:0] wdataReg;
  logic [cntW-1:0]      beatCnt;  // beats left after the current one
  logic                 accept;
  logic                 beat;
  logic                 isWrite;
  logic                 fifoFull;

  assign ctl.reqReady = (state == stIdle) && busGnt;
  assign accept       = ctl.reqValid && ctl.reqReady;
  assign isWrite      = opReg == opWrite;

  // throttle read beats on a full FIFO
  assign busIrdy  = (state == stData || state == stLast) && (isWrite || !fifoFull);
  assign beat     = busIrdy && busTrdy;
  assign busReq   = (state == stIdle) && ctl.reqValid;
  assign busFrame = (state == stAddr) || (state == stData);
  assign busDrive = (state == stAddr) || (state == stData) || (state == stLast);
  assign busWrite = busDrive && isWrite;
  assign busAddr  = addrReg;
  assign busWdata = wdataReg;
  assign ctl.done = (state == stLast) && beat;

  always_comb
  begin
    stateNext = state;
    unique case (state)
      stIdle:
        if (accept)
          stateNext = stAddr;
      stAddr:
        stateNext = (beatCnt == '0) ? stLast : stData;
      stData:
        if (beat && beatCnt == cntW'(1))
          stateNext = stLast; // frame drops here
      stLast:
        if (beat)
          stateNext = stTurn;
      stTurn:
        stateNext = stIdle;
      default:
        stateNext = stIdle;
    endcase
  end

  always_ff @(posedge BUSCLK)
  begin
    if (reset)
    begin
      state   <= stIdle;
      opReg   <= opRead;
      beatCnt <= '0;
    end
    else
    begin
      state <= stateNext;
      if (accept)
      begin
        opReg <= ctl.reqOp;
        if (ctl.reqOp == opReadLine)
          beatCnt <= cntW'(lineWords - 1);
        else
          beatCnt <= '0;
      end
      else if (beat)
        beatCnt <= beatCnt - 1'b1;
    end
  end

  // address and write data
  always_ff @(posedge BUSCLK)
  begin
    if (accept)
    begin
      wdataReg <= ctl.reqWdata;
      if (ctl.reqOp == opReadLine)
        addrReg <= ctl.reqAddr & ~lineMask; // line base
      else
        addrReg <= ctl.reqAddr;
    end
    else if (beat)
      addrReg <= addrReg + addrWidth'(4);
  end

  readDataFifo #(
    .fifoDepth (fifoDepth)
  ) rdFifo (
    .BUSCLK   (BUSCLK),
    .reset    (reset),
    .push     (beat && !isWrite),
    .pushData (busRdata),
    .popValid (ctl.rspValid),
    .popReady (ctl.rspReady),
    .popData  (ctl.rspData),
    .full     (fifoFull)
  );

  // frame only follows a granted accept
  assert property (@(posedge BUSCLK) disable iff (reset) $rose(busFrame) |-> $past(busGnt));

endmodule

`default_nettype wire

// ==== source/localBus.sv ====
`timescale 1ns/1ns
`default_nettype none

module localBus
  import localBusPkg::*;
#(
  parameter int lineWords = 4,
  parameter int fifoDepth = 4
)
(
  input  logic                 BUSCLK,
  input  logic                 reset,
  // port 0
  input  logic                 p0ReqValid,
  input  lbusOp_e              p0ReqOp,
  input  logic [addrWidth-1:0] p0ReqAddr,
  input  logic [dataWidth-1:0] p0ReqWdata,
  input  logic                 p0RspReady,
  output logic                 p0ReqReady,
  output logic                 p0RspValid,
  output logic [dataWidth-1:0] p0RspData,
  // port 1
  input  logic                 p1ReqValid,
  input  lbusOp_e              p1ReqOp,
  input  logic [addrWidth-1:0] p1ReqAddr,
  input  logic [dataWidth-1:0] p1ReqWdata,
  input  logic                 p1RspReady,
  output logic                 p1ReqReady,
  output logic                 p1RspValid,
  output logic [dataWidth-1:0] p1RspData,
  // external bus
  input  logic                 busGnt,
  input  logic                 busTrdy,
  input  logic [dataWidth-1:0] busRdata,
  output logic                 busReq,
  output logic                 busFrame,
  output logic                 busIrdy,
  output logic                 busDrive,
  output logic                 busWrite,
  output logic [addrWidth-1:0] busAddr,
  output logic [dataWidth-1:0] busWdata
);

  lbusReqIf p0If ();
  lbusReqIf p1If ();
  lbusReqIf toMaster ();

  assign p0If.reqValid = p0ReqValid;
  assign p0If.reqOp    = p0ReqOp;
  assign p0If.reqAddr  = p0ReqAddr;
  assign p0If.reqWdata = p0ReqWdata;
  assign p0If.rspReady = p0RspReady;
  assign p0ReqReady    = p0If.reqReady;
  assign p0RspValid    = p0If.rspValid;
  assign p0RspData     = p0If.rspData;

  assign p1If.reqValid = p1ReqValid;
  assign p1If.reqOp    = p1ReqOp;
  assign p1If.reqAddr  = p1ReqAddr;
  assign p1If.reqWdata = p1ReqWdata;
  assign p1If.rspReady = p1RspReady;
  assign p1ReqReady    = p1If.reqReady;
  assign p1RspValid    = p1If.rspValid;
  assign p1RspData     = p1If.rspData;

  lbusReqArbiter #(
    .lineWords (lineWords)
  ) reqArbiter (
    .BUSCLK   (BUSCLK),
    .reset    (reset),
    .port0    (p0If.controller),
    .port1    (p1If.controller),
    .toMaster (toMaster.requester)
  );

  lbusMaster #(
    .lineWords (lineWords),
    .fifoDepth (fifoDepth)
  ) busMaster (
    .BUSCLK   (BUSCLK),
    .reset    (reset),
    .ctl      (toMaster.controller),
    .busGnt   (busGnt),
    .busTrdy  (busTrdy),
    .busRdata (busRdata),
    .busReq   (busReq),
    .busFrame (busFrame),
    .busIrdy  (busIrdy),
    .busDrive (busDrive),
    .busWrite (busWrite),
    .busAddr  (busAddr),
    .busWdata (busWdata)
  );

endmodule

`default_nettype wire

// ==== testbench/busTargetModel.sv ====
`timescale 1ns/1ns
`default_nettype none

module busTargetModel
  import localBusPkg::*;
#(
  parameter logic [31:0] seed = 32'd2881
)
(
  input  logic                 BUSCLK,
  input  logic                 reset,
  input  logic                 busReq,
  input  logic                 busFrame,
  input  logic                 busIrdy,
  input  logic                 busWrite,
  input  logic [addrWidth-1:0] busAddr,
  input  logic [dataWidth-1:0] busWdata,
  output logic                 busGnt,
  output logic                 busTrdy,
  output logic [dataWidth-1:0] busRdata
);
  logic [31:0]          rngState = seed;
  logic [dataWidth-1:0] wrData [64]; // written words tagged by full address
  logic [addrWidth-1:0] wrTag [64];
  logic                 wrHit [64];
  logic [addrWidth-1:0] beatAddr;
  logic                 active;   // between address phase and last beat
  int                   gntWait;
  int                   trdyWait;

  function automatic logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  function automatic logic [dataWidth-1:0] readWord(input logic [addrWidth-1:0] a);
    if (wrHit[a[7:2]] && wrTag[a[7:2]] == a)
      return wrData[a[7:2]];
    return {~a[31:16], a[15:0]}; // never written
  endfunction

  initial
  begin
    busGnt   = 1'b0;
    busTrdy  = 1'b0;
    busRdata = '0;
    for (int i = 0; i < 64; i++)
      wrHit[i] = 1'b0;
  end

  always @(posedge BUSCLK)
  begin
    if (reset)
    begin
      busGnt   <= 1'b0;
      busTrdy  <= 1'b0;
      busRdata <= '0;
      active   <= 1'b0;
      gntWait  <= nextRand() % 4;
      trdyWait <= 0;
    end
    else
    begin
      if (!busReq)
      begin
        busGnt  <= 1'b0;
        gntWait <= nextRand() % 4;
      end
      else if (!busGnt)
      begin
        if (gntWait == 0)
          busGnt <= 1'b1;
        else
          gntWait <= gntWait - 1;
      end

      if (!active)
      begin
        if (busFrame)
        begin
          active   <= 1'b1;
          beatAddr <= busAddr; // address phase
          trdyWait <= nextRand() % 3;
        end
      end
      else if (busTrdy)
      begin
        if (busIrdy)
        begin
          if (busWrite)
          begin
            wrHit[beatAddr[7:2]]  <= 1'b1;
            wrTag[beatAddr[7:2]]  <= beatAddr;
            wrData[beatAddr[7:2]] <= busWdata;
          end
          busTrdy  <= 1'b0;
          beatAddr <= beatAddr + 4;
          trdyWait <= nextRand() % 3;
          if (!busFrame)
            active <= 1'b0; // that was the last beat
        end
      end
      else if (trdyWait == 0)
      begin
        busTrdy  <= 1'b1;
        busRdata <= readWord(beatAddr);
      end
      else
        trdyWait <= trdyWait - 1;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/localBusTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module localBusTb
  import localBusPkg::*;
();
  localparam int lineWords = 8; // longer than the FIFO so IRDY throttles
  localparam int fifoDepth = 4;
  localparam int lineBytes = lineWords * 4;
  localparam int expectedBeats = 8 + 2 * lineWords;
  localparam int cycleLimit = 40 * expectedBeats + 200;

  logic                 BUSCLK;
  logic                 reset;
  logic                 p0ReqValid;
  lbusOp_e              p0ReqOp;
  logic [addrWidth-1:0] p0ReqAddr;
  logic [dataWidth-1:0] p0ReqWdata;
  logic                 p0RspReady;
  logic                 p0ReqReady;
  logic                 p0RspValid;
  logic [dataWidth-1:0] p0RspData;
  logic                 p1ReqValid;
  lbusOp_e              p1ReqOp;
  logic [addrWidth-1:0] p1ReqAddr;
  logic [dataWidth-1:0] p1ReqWdata;
  logic                 p1RspReady;
  logic                 p1ReqReady;
  logic                 p1RspValid;
  logic [dataWidth-1:0] p1RspData;
  logic                 busGnt;
  logic                 busTrdy;
  logic [dataWidth-1:0] busRdata;
  logic                 busReq;
  logic                 busFrame;
  logic                 busIrdy;
  logic                 busDrive;
  logic                 busWrite;
  logic [addrWidth-1:0] busAddr;
  logic [dataWidth-1:0] busWdata;

  int                   errors = 0;
  int                   checks = 0;
  int                   tests = 0;
  int                   cycles = 0;
  int                   fifoLevel = 0; // expected read FIFO occupancy
  logic                 prevFrame;
  logic                 sawFull;
  logic [addrWidth-1:0] phaseAddrs [$];
  logic [addrWidth-1:0] shadowAddr [$];
  logic [dataWidth-1:0] shadowData [$];

  localBus #(
    .lineWords (lineWords),
    .fifoDepth (fifoDepth)
  ) i_dut (.*);

  busTargetModel #(
    .seed (32'd2881)
  ) target (.*);

  initial
  begin
    BUSCLK = 1'b0;
    forever #4 BUSCLK = ~BUSCLK;
  end

  always @(posedge BUSCLK)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit)
    begin
      $display("timeout after %0d cycles, a transaction never finished", cycles);
      $display("Test failed");
      $finish;
    end
  end

  // address phases and expected FIFO level
  always @(posedge BUSCLK)
  begin
    if (reset)
    begin
      prevFrame <= 1'b0;
      fifoLevel <= 0;
    end
    else
    begin
      prevFrame <= busFrame;
      if (busFrame && !prevFrame)
        phaseAddrs.push_back(busAddr);
      if (fifoLevel == fifoDepth)
        sawFull <= 1'b1;
      if (busIrdy && !busWrite && fifoLevel == fifoDepth)
      begin
        $display("[ERROR] busIrdy was high while the read FIFO was full");
        errors++;
      end
      fifoLevel <= fifoLevel + int'(busIrdy && busTrdy && !busWrite)
        - int'((p0RspValid && p0RspReady) || (p1RspValid && p1RspReady));
    end
  end

  function automatic logic [dataWidth-1:0] shadowWord(input logic [addrWidth-1:0] a);
    for (int i = shadowAddr.size() - 1; i >= 0; i--)
      if (shadowAddr[i] == a)
        return shadowData[i];
    return {~a[31:16], a[15:0]};
  endfunction

  task automatic shadowWrite(input logic [addrWidth-1:0] a, input logic [dataWidth-1:0] d);
    shadowAddr.push_back(a);
    shadowData.push_back(d);
  endtask

  task automatic checkData(input string name, input logic [dataWidth-1:0] expected,
                           input logic [dataWidth-1:0] actual);
    checks++;
    if (actual !== expected)
    begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic checkAddr(input string name, input logic [addrWidth-1:0] expected,
                           input logic [addrWidth-1:0] actual);
    checks++;
    if (actual !== expected)
    begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic reportFailure(input string name, input string what);
    $display("[ERROR] %s: %s", name, what);
    errors++;
  endtask

  task automatic checkPhase(input string name, input logic [addrWidth-1:0] expected);
    if (phaseAddrs.size() == 0)
      reportFailure(name, "no address phase was seen on the bus");
    else
      checkAddr(name, expected, phaseAddrs.pop_front());
  endtask

  task automatic finishTest(input string name, input int errStart);
    tests++;
    $display("%s: %s", name, (errors == errStart) ? "ok" : "mismatches found");
  endtask

  task automatic applyReset();
    reset <= 1'b1;
    repeat (10) @(posedge BUSCLK);
    reset <= 1'b0;
    @(posedge BUSCLK);
  endtask

  // returns on the edge where the request was taken
  task automatic sendReq(input bit port, input lbusOp_e op,
                         input logic [addrWidth-1:0] addr, input logic [dataWidth-1:0] wdata);
    bit taken;
    taken = 1'b0;
    if (port)
    begin
      p1ReqOp    <= op;
      p1ReqAddr  <= addr;
      p1ReqWdata <= wdata;
      p1ReqValid <= 1'b1;
    end
    else
    begin
      p0ReqOp    <= op;
      p0ReqAddr  <= addr;
      p0ReqWdata <= wdata;
      p0ReqValid <= 1'b1;
    end
    while (!taken)
    begin
      @(posedge BUSCLK);
      taken = port ? p1ReqReady : p0ReqReady;
    end
    if (port)
      p1ReqValid <= 1'b0;
    else
      p0ReqValid <= 1'b0;
  endtask

  // words are expected in ascending address order from base
  task automatic recvCheck(input bit port, input string name,
                           input logic [addrWidth-1:0] base, input int count);
    int got;
    got = 0;
    if (port)
      p1RspReady <= 1'b1;
    else
      p0RspReady <= 1'b1;
    while (got < count)
    begin
      @(posedge BUSCLK);
      if (port ? p1RspValid : p0RspValid)
      begin
        checkData(name, shadowWord(base + addrWidth'(4 * got)), port ? p1RspData : p0RspData);
        got++;
      end
    end
    if (port)
      p1RspReady <= 1'b0;
    else
      p0RspReady <= 1'b0;
  endtask

  task automatic resetTest();
    int errStart;
    errStart = errors;
    if ({busReq, busFrame, busIrdy, busDrive} !== 4'b0)
      reportFailure("reset", "a bus control output is not low after reset");
    if ({p0ReqReady, p1ReqReady, p0RspValid, p1RspValid} !== 4'b0)
      reportFailure("reset", "a port handshake output is not low after reset");
    finishTest("reset", errStart);
  endtask

  task automatic writeReadTest();
    int errStart;
    logic [addrWidth-1:0] addr;
    errStart = errors;
    addr = 32'h1000_0044; // word inside a line
    phaseAddrs.delete();
    sendReq(1'b0, opWrite, addr, 32'hcafe_0001);
    shadowWrite(addr, 32'hcafe_0001);
    sendReq(1'b0, opRead, addr, '0);
    recvCheck(1'b0, "writeRead", addr, 1);
    checkPhase("writeRead", addr);
    checkPhase("writeRead", addr);
    finishTest("writeRead", errStart);
  endtask

  task automatic lineReadTest();
    int errStart;
    logic [addrWidth-1:0] addr;
    logic [addrWidth-1:0] base;
    errStart = errors;
    addr = 32'h2000_0014; // middle of a line
    base = addr & ~addrWidth'(lineBytes - 1);
    phaseAddrs.delete();
    sendReq(1'b0, opReadLine, addr, '0);
    recvCheck(1'b0, "lineRead", base, lineWords);
    checkPhase("lineRead", base);
    finishTest("lineRead", errStart);
  endtask

  task automatic backPressureTest();
    int errStart;
    logic [addrWidth-1:0] addr;
    errStart = errors;
    addr = 32'h2400_0008;
    sawFull = 1'b0;
    sendReq(1'b1, opReadLine, addr, '0);
    repeat (20) @(posedge BUSCLK); // RspReady held low
    if (!sawFull)
      reportFailure("backPressure", "the read FIFO never filled while RspReady was low");
    recvCheck(1'b1, "backPressure", addr & ~addrWidth'(lineBytes - 1), lineWords);
    repeat (4) @(posedge BUSCLK);
    if (p1RspValid !== 1'b0)
      reportFailure("backPressure", "an extra response word followed the line");
    finishTest("backPressure", errStart);
  endtask

  // p0 re-requests as soon as it is served so the pointer alone decides
  task automatic arbitrationTest();
    int errStart;
    errStart = errors;
    applyReset();
    phaseAddrs.delete();
    fork
      begin
        sendReq(1'b0, opRead, 32'h3000_0100, '0);
        recvCheck(1'b0, "arbitration", 32'h3000_0100, 1);
        sendReq(1'b0, opRead, 32'h3200_0308, '0);
        recvCheck(1'b0, "arbitration", 32'h3200_0308, 1);
      end
      begin
        sendReq(1'b1, opRead, 32'h3100_0204, '0);
        recvCheck(1'b1, "arbitration", 32'h3100_0204, 1);
      end
    join
    checkPhase("arbitration", 32'h3000_0100);
    checkPhase("arbitration", 32'h3100_0204);
    checkPhase("arbitration", 32'h3200_0308);
    finishTest("arbitration", errStart);
  endtask

  task automatic interleaveTest();
    int errStart;
    logic [addrWidth-1:0] addr;
    errStart = errors;
    addr = 32'h1000_0080;
    // port 0 was served last so port 1 reads the old word first
    fork
      sendReq(1'b0, opWrite, addr, 32'h5a5a_0006);
      begin
        sendReq(1'b1, opRead, addr, '0);
        recvCheck(1'b1, "interleave", addr, 1);
      end
    join
    shadowWrite(addr, 32'h5a5a_0006);
    sendReq(1'b0, opRead, addr, '0);
    recvCheck(1'b0, "interleave", addr, 1);
    finishTest("interleave", errStart);
  endtask

  initial
  begin
    reset = 1'b1;
    sawFull = 1'b0;
    p0ReqValid = 1'b0;
    p0ReqOp = opRead;
    p0ReqAddr = '0;
    p0ReqWdata = '0;
    p0RspReady = 1'b0;
    p1ReqValid = 1'b0;
    p1ReqOp = opRead;
    p1ReqAddr = '0;
    p1ReqWdata = '0;
    p1RspReady = 1'b0;
    applyReset();
    resetTest();
    writeReadTest();
    lineReadTest();
    backPressureTest();
    arbitrationTest();
    interleaveTest();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== localBus.f ====
source/localBusPkg.sv
source/lbusReqIf.sv
source/readDataFifo.sv
source/lbusReqArbiter.sv
source/lbusMaster.sv
source/localBus.sv
testbench/busTargetModel.sv
testbench/localBusTb.sv
